//--- project.f
src/bilinear_pkg.sv
src/bilinear_fetch.sv
src/texel_memory.sv
src/bilinear_accum.sv
src/user_fifo.sv
src/bilinear_top.sv
dv/bilinear_tb.sv

//--- dv/bilinear_tb.sv
/* self-checking testbench for the bilinear sampler that loads a random image,
   sends coordinates and checks every pixel and tag against a reference model */

`timescale 1ns/1ps
`default_nettype none

module bilinear_tb;

	// 300 coordinates, stalls and the image load stay well under this
	localparam int cycle_limit = 5000;

	logic                                 clk;
	logic                                 reset;
	bilinear_pkg::coord_t                 s_coord;
	logic [bilinear_pkg::user_width-1:0]  s_user;
	logic                                 s_valid;
	logic                                 s_ready;
	bilinear_pkg::pixel_t                 m_pixel;
	logic [bilinear_pkg::user_width-1:0]  m_user;
	logic                                 m_valid;
	logic                                 m_ready;
	logic                                 wr_en;
	logic [2*bilinear_pkg::int_width-1:0] wr_addr;
	bilinear_pkg::pixel_t                 wr_pixel;

	// reference copy of the image indexed {y, x}
	bilinear_pkg::pixel_t                image [256];
	bilinear_pkg::pixel_t                exp_pixel_q [$];
	logic [bilinear_pkg::user_width-1:0] exp_user_q [$];

	integer                              seed;
	int                                  mismatch_count = 0;
	int                                  other_count = 0;
	int                                  checked_count = 0;
	int                                  sent_count = 0;
	int                                  cycle_count = 0;
	logic                                random_ready;
	logic [bilinear_pkg::user_width-1:0] tag_next;
	logic                                accepted_any = 1'b0;
	logic                                prev_stall = 1'b0;
	bilinear_pkg::pixel_t                prev_pixel;
	logic [bilinear_pkg::user_width-1:0] prev_user;

	bilinear_top dut0 (
		.clk      (clk),
		.reset    (reset),
		.s_coord  (s_coord),
		.s_user   (s_user),
		.s_valid  (s_valid),
		.s_ready  (s_ready),
		.m_pixel  (m_pixel),
		.m_user   (m_user),
		.m_valid  (m_valid),
		.m_ready  (m_ready),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_pixel (wr_pixel)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// --------------------
	// reference model
	// --------------------
	function automatic bilinear_pkg::pixel_t expected_pixel(input bilinear_pkg::coord_t c);
		int                   sum [bilinear_pkg::comp_num];
		int                   xi;
		int                   yi;
		int                   wx;
		int                   wy;
		bilinear_pkg::pixel_t res;
		for (int k = 0; k < bilinear_pkg::comp_num; k++) begin
			sum[k] = 0;
		end
		for (int p = 0; p < 4; p++) begin
			// neighbours wrap at the image edge
			xi = (c.x_int + (p & 1)) % 16;
			yi = (c.y_int + ((p >> 1) & 1)) % 16;
			wx = (p & 1) ? c.x_frac : 16 - c.x_frac;
			wy = (p & 2) ? c.y_frac : 16 - c.y_frac;
			for (int k = 0; k < bilinear_pkg::comp_num; k++) begin
				sum[k] += wx * wy * image[yi * 16 + xi][k];
			end
		end
		for (int k = 0; k < bilinear_pkg::comp_num; k++) begin
			res[k] = sum[k] >> 8;
		end
		return res;
	endfunction

	function automatic bilinear_pkg::coord_t make_coord(input int xi, input int xf,
			input int yi, input int yf);
		bilinear_pkg::coord_t c;
		c.x_int  = xi;
		c.x_frac = xf;
		c.y_int  = yi;
		c.y_frac = yf;
		return c;
	endfunction

	// --------------------
	// stimulus
	// --------------------
	task automatic step();
		@(posedge clk);
		if (random_ready) begin
			m_ready <= (($random(seed) & 1) == 1);
		end
	endtask

	// holds the coordinate until the fourth phase takes it
	task automatic send_coord(input bilinear_pkg::coord_t c);
		s_coord <= c;
		s_user  <= tag_next;
		s_valid <= 1'b1;
		step();
		while (!s_ready) begin
			step();
		end
		tag_next++;
		sent_count++;
	endtask

	// --------------------
	// monitor
	// --------------------
	always @(posedge clk) begin
		if (!reset) begin
			if (!accepted_any) begin
				assert (!m_valid) else begin
					$display("MISMATCH at %0t: m_valid high before any coordinate", $time);
					mismatch_count++;
				end
			end
			if (prev_stall) begin
				assert (m_valid && m_pixel == prev_pixel && m_user == prev_user) else begin
					$display("MISMATCH at %0t: output changed while stalled, %h/%h now %h/%h",
						$time, prev_pixel, prev_user, m_pixel, m_user);
					mismatch_count++;
				end
			end
			if (s_valid && s_ready) begin
				exp_pixel_q.push_back(expected_pixel(s_coord));
				exp_user_q.push_back(s_user);
				accepted_any = 1'b1;
			end
			if (m_valid && m_ready) begin
				if (exp_pixel_q.size() == 0) begin
					$display("an output appeared with no coordinate pending at %0t", $time);
					other_count++;
				end else begin
					assert (m_pixel == exp_pixel_q[0] && m_user == exp_user_q[0]) else begin
						$display("MISMATCH at %0t: expected pixel %h tag %h, got pixel %h tag %h",
							$time, exp_pixel_q[0], exp_user_q[0], m_pixel, m_user);
						mismatch_count++;
					end
					void'(exp_pixel_q.pop_front());
					void'(exp_user_q.pop_front());
					checked_count++;
				end
			end
			prev_stall = m_valid && !m_ready;
			prev_pixel = m_pixel;
			prev_user  = m_user;
		end
	end

	initial begin
		bilinear_pkg::pixel_t px;
		seed         = 74;
		reset        = 1'b1;
		s_coord      = '0;
		s_user       = '0;
		s_valid      = 1'b0;
		m_ready      = 1'b1;
		wr_en        = 1'b0;
		wr_addr      = '0;
		wr_pixel     = '0;
		random_ready = 1'b0;
		tag_next     = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// random image through the write port
		for (int a = 0; a < 256; a++) begin
			@(posedge clk);
			px = $random(seed);
			image[a] = px;
			wr_en    <= 1'b1;
			wr_addr  <= a;
			wr_pixel <= px;
		end
		@(posedge clk);
		wr_en <= 1'b0;

		// zero fractions return the stored texel
		for (int i = 0; i < 32; i++) begin
			send_coord(make_coord($random(seed), 0, $random(seed), 0));
		end
		for (int i = 0; i < 120; i++) begin
			send_coord(make_coord($random(seed), $random(seed), $random(seed), $random(seed)));
		end
		// edge coordinates that wrap to column or row 0
		for (int i = 0; i < 48; i++) begin
			send_coord(make_coord((i % 2 == 1) ? 15 : $random(seed), $random(seed),
				(i % 3 != 0) ? 15 : $random(seed), $random(seed)));
		end

		// random output back-pressure with idle gaps
		random_ready = 1'b1;
		for (int i = 0; i < 100; i++) begin
			send_coord(make_coord($random(seed), $random(seed), $random(seed), $random(seed)));
			if (($random(seed) & 3) == 0) begin
				s_valid <= 1'b0;
				step();
			end
		end
		s_valid <= 1'b0;
		while (checked_count < sent_count) begin
			step();
		end
		random_ready = 1'b0;
		m_ready <= 1'b1;
		repeat (20) step();

		$display("errors: %0d mismatches, %0d other, %0d results checked",
			mismatch_count, other_count, checked_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/bilinear_top.sv
/* bilinear texture sampler: coordinate and tag in, weighted pixel and tag
   out, with a strobe port for loading the texel image */

`timescale 1ns/1ps
`default_nettype none

module bilinear_top (
	input  logic                                 clk,
	input  logic                                 reset,
	input  bilinear_pkg::coord_t                 s_coord,
	input  logic [bilinear_pkg::user_width-1:0]  s_user,
	input  logic                                 s_valid,
	output logic                                 s_ready,
	output bilinear_pkg::pixel_t                 m_pixel,
	output logic [bilinear_pkg::user_width-1:0]  m_user,
	output logic                                 m_valid,
	input  logic                                 m_ready,
	input  logic                                 wr_en,
	input  logic [2*bilinear_pkg::int_width-1:0] wr_addr,
	input  bilinear_pkg::pixel_t                 wr_pixel
);

	// read request and response channels
	bilinear_pkg::mem_req_t  ar;
	logic                    ar_valid;
	logic                    ar_ready;
	bilinear_pkg::mem_resp_t r;
	logic                    r_valid;
	logic                    r_ready;

	logic user_push;
	logic user_pop;

	assign user_push = s_valid && s_ready;
	assign user_pop  = m_valid && m_ready;

	bilinear_fetch fetch0 (
		.clk      (clk),
		.reset    (reset),
		.s_coord  (s_coord),
		.s_valid  (s_valid),
		.s_ready  (s_ready),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready)
	);

	texel_memory mem0 (
		.clk      (clk),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_pixel (wr_pixel),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

	bilinear_accum accum0 (
		.clk     (clk),
		.reset   (reset),
		.r       (r),
		.r_valid (r_valid),
		.r_ready (r_ready),
		.m_pixel (m_pixel),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

	// tags bypass the datapath, order is preserved end to end
	user_fifo fifo0 (
		.clk       (clk),
		.reset     (reset),
		.push      (user_push),
		.push_data (s_user),
		.pop       (user_pop),
		.head      (m_user)
	);

endmodule

`default_nettype wire

//--- src/user_fifo.sv
/* first-word-fall-through tag FIFO, pushed on input acceptance and popped
   on output acceptance; the head is always visible */

`timescale 1ns/1ps
`default_nettype none

module user_fifo (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                push,
	input  logic [bilinear_pkg::user_width-1:0] push_data,
	input  logic                                pop,
	output logic [bilinear_pkg::user_width-1:0] head
);

	logic [bilinear_pkg::user_width-1:0] store [bilinear_pkg::fifo_depth];

	// pointers wrap with the buffer
	logic [$clog2(bilinear_pkg::fifo_depth)-1:0] wr_ptr;
	logic [$clog2(bilinear_pkg::fifo_depth)-1:0] rd_ptr;

	// --------------------
	// pointers
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			store[wr_ptr] <= push_data;
		end
	end

	// fall-through read
	assign head = store[rd_ptr];

endmodule

`default_nettype wire

//--- src/bilinear_accum.sv
/* weights and sums four consecutive texel beats per component and emits
   one pixel per group, with full stall on output back-pressure */

`timescale 1ns/1ps
`default_nettype none

module bilinear_accum (
	input  logic                    clk,
	input  logic                    reset,
	input  bilinear_pkg::mem_resp_t r,
	input  logic                    r_valid,
	output logic                    r_ready,
	output bilinear_pkg::pixel_t    m_pixel,
	output logic                    m_valid,
	input  logic                    m_ready
);

	logic       advance;
	logic       take;
	logic [1:0] beat;

	// register stage
	logic                                 st0_valid;
	logic                                 st0_load;
	logic                                 st0_last;
	logic [bilinear_pkg::coeff_width-1:0] st0_coeff;
	bilinear_pkg::pixel_t                 st0_data;

	// multiply stage
	logic st1_valid;
	logic st1_load;
	logic st1_last;
	logic [bilinear_pkg::coeff_width+bilinear_pkg::data_width-1:0] prod [bilinear_pkg::comp_num];

	// accumulate stage
	logic st2_last;
	logic [bilinear_pkg::coeff_width+bilinear_pkg::data_width-1:0] acc [bilinear_pkg::comp_num];

	assign advance = !m_valid || m_ready;
	assign r_ready = advance;
	assign take    = r_valid && r_ready;

	// --------------------
	// control
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			beat      <= 2'd0;
			st0_valid <= 1'b0;
			st0_load  <= 1'b0;
			st0_last  <= 1'b0;
			st1_valid <= 1'b0;
			st1_load  <= 1'b0;
			st1_last  <= 1'b0;
			st2_last  <= 1'b0;
			m_valid   <= 1'b0;
		end else if (advance) begin
			if (take) begin
				beat <= beat + 2'd1;
			end
			// first beat restarts the sum, fourth closes it
			st0_valid <= take;
			st0_load  <= take && (beat == 2'd0);
			st0_last  <= take && (beat == 2'd3);

			st1_valid <= st0_valid;
			st1_load  <= st0_load;
			st1_last  <= st0_last;

			st2_last <= st1_last;
			m_valid  <= st2_last;
		end
	end

	// --------------------
	// datapath
	// --------------------
	always_ff @(posedge clk) begin
		if (advance) begin
			st0_coeff <= r.coeff;
			st0_data  <= r.data;
			for (int i = 0; i < bilinear_pkg::comp_num; i++) begin
				prod[i] <= st0_coeff * st0_data[i];
				if (st1_valid) begin
					acc[i] <= st1_load ? prod[i] : acc[i] + prod[i];
				end
				// drop the weight fraction, truncating
				if (st2_last) begin
					m_pixel[i] <= acc[i][2*bilinear_pkg::frac_width +: bilinear_pkg::data_width];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/texel_memory.sv
/* 16x16 RGB texel store, loaded through a strobe write port and read
   through a valid/ready channel that returns each request's weight */

`timescale 1ns/1ps
`default_nettype none

module texel_memory (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           wr_en,
	input  logic [2*bilinear_pkg::int_width-1:0] wr_addr,
	input  bilinear_pkg::pixel_t           wr_pixel,
	input  bilinear_pkg::mem_req_t         ar,
	input  logic                           ar_valid,
	output logic                           ar_ready,
	output bilinear_pkg::mem_resp_t        r,
	output logic                           r_valid,
	input  logic                           r_ready
);

	// address is {y, x}, y selects the row
	bilinear_pkg::pixel_t mem [2**(2*bilinear_pkg::int_width)];

	logic                                 rd_take;
	logic [2*bilinear_pkg::int_width-1:0] rd_addr;

	assign ar_ready = !r_valid || r_ready;
	assign rd_take  = ar_valid && ar_ready;
	assign rd_addr  = {ar.y, ar.x};

	// --------------------
	// image load
	// --------------------
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_pixel;
		end
	end

	// --------------------
	// read channel
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (rd_take) begin
			r_valid <= 1'b1;
		end else if (r_ready) begin
			r_valid <= 1'b0;
		end
	end

	// weight rides beside its texel, held while stalled
	always_ff @(posedge clk) begin
		if (rd_take) begin
			r.data  <= mem[rd_addr];
			r.coeff <= ar.coeff;
		end
	end

endmodule

`default_nettype wire

//--- src/bilinear_fetch.sv
/* turns each input coordinate into four weighted neighbour read requests
   through a select, delay, multiply and align pipeline */

`timescale 1ns/1ps
`default_nettype none

module bilinear_fetch (
	input  logic                 clk,
	input  logic                 reset,
	input  bilinear_pkg::coord_t s_coord,
	input  logic                 s_valid,
	output logic                 s_ready,
	output bilinear_pkg::mem_req_t ar,
	output logic                 ar_valid,
	input  logic                 ar_ready
);

	logic       advance;
	logic [1:0] phase;

	// axis weights for both neighbours of the current coordinate
	logic [bilinear_pkg::frac_width:0] wx0;
	logic [bilinear_pkg::frac_width:0] wx1;
	logic [bilinear_pkg::frac_width:0] wy0;
	logic [bilinear_pkg::frac_width:0] wy1;

	// select stage
	logic [bilinear_pkg::int_width-1:0] st0_x;
	logic [bilinear_pkg::int_width-1:0] st0_y;
	logic [bilinear_pkg::frac_width:0]  st0_wx;
	logic [bilinear_pkg::frac_width:0]  st0_wy;
	logic                               st0_valid;

	// delay stage
	logic [bilinear_pkg::int_width-1:0] st1_x;
	logic [bilinear_pkg::int_width-1:0] st1_y;
	logic [bilinear_pkg::frac_width:0]  st1_wx;
	logic [bilinear_pkg::frac_width:0]  st1_wy;
	logic                               st1_valid;

	// multiply stage
	logic [bilinear_pkg::int_width-1:0]   st2_x;
	logic [bilinear_pkg::int_width-1:0]   st2_y;
	logic [bilinear_pkg::coeff_width-1:0] st2_coeff;
	logic                                 st2_valid;

	assign wx0 = {1'b1, {bilinear_pkg::frac_width{1'b0}}} - {1'b0, s_coord.x_frac};
	assign wx1 = {1'b0, s_coord.x_frac};
	assign wy0 = {1'b1, {bilinear_pkg::frac_width{1'b0}}} - {1'b0, s_coord.y_frac};
	assign wy1 = {1'b0, s_coord.y_frac};

	// whole pipeline moves together or holds
	assign advance = !ar_valid || ar_ready;

	// coordinate is consumed with its last neighbour
	assign s_ready = advance && (phase == 2'd3);

	// --------------------
	// control
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			phase     <= 2'd0;
			st0_valid <= 1'b0;
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
			ar_valid  <= 1'b0;
		end else if (advance) begin
			if (s_valid) begin
				phase <= phase + 2'd1;
			end
			st0_valid <= s_valid;
			st1_valid <= st0_valid;
			st2_valid <= st1_valid;
			ar_valid  <= st2_valid;
		end
	end

	// --------------------
	// datapath
	// --------------------
	always_ff @(posedge clk) begin
		if (advance) begin
			// phase bit 0 picks the x neighbour, bit 1 the y neighbour
			st0_x  <= s_coord.x_int + phase[0];
			st0_y  <= s_coord.y_int + phase[1];
			st0_wx <= phase[0] ? wx1 : wx0;
			st0_wy <= phase[1] ? wy1 : wy0;

			st1_x  <= st0_x;
			st1_y  <= st0_y;
			st1_wx <= st0_wx;
			st1_wy <= st0_wy;

			st2_x     <= st1_x;
			st2_y     <= st1_y;
			st2_coeff <= st1_wx * st1_wy;

			ar.coeff <= st2_coeff;
			ar.x     <= st2_x;
			ar.y     <= st2_y;
		end
	end

endmodule

`default_nettype wire

//--- src/bilinear_pkg.sv
/* shared widths, image size and bus structs for the bilinear sampler
   referenced by scoped name from every RTL block and the testbench */

`default_nettype none

package bilinear_pkg;

	// --------------------
	// sizes
	// --------------------
	localparam int comp_num    = 3;
	localparam int data_width  = 8;
	localparam int int_width   = 4;
	localparam int frac_width  = 4;
	// one extra integer bit so a weight of exactly 1.0 fits
	localparam int coeff_width = 1 + 2 * frac_width;
	localparam int user_width  = 8;
	localparam int fifo_depth  = 16;

	// --------------------
	// bus payloads
	// --------------------

	// one input coordinate, integer and fraction per axis
	typedef struct packed {
		logic [int_width-1:0]  x_int;
		logic [frac_width-1:0] x_frac;
		logic [int_width-1:0]  y_int;
		logic [frac_width-1:0] y_frac;
	} coord_t;

	// component 0 sits in the low byte
	typedef logic [comp_num-1:0][data_width-1:0] pixel_t;

	// texel read request with its bilinear weight
	typedef struct packed {
		logic [coeff_width-1:0] coeff;
		logic [int_width-1:0]   x;
		logic [int_width-1:0]   y;
	} mem_req_t;

	typedef struct packed {
		logic [coeff_width-1:0] coeff;
		pixel_t                 data;
	} mem_resp_t;

endpackage

`default_nettype wire
